// File: sources.f
+incdir+.
pipe_pkg.sv
instr_intake.sv
hazard_unit.sv
exec_mem_pipe.sv
data_mem.sv
result_port.sv
pipe_top.sv
tb_clock.sv
pipe_props.sv
pipe_tb.sv

// File: Makefile
# Verilator build and run of the pipeline testbench.
VERILATOR ?= verilator
TOP       ?= pipe_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := pipe_defs.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: pipe_tb.sv
// runs a fixed instruction table through pipe_top and checks
// every result record in order.
`timescale 1ns/1ps
`include "pipe_defs.svh"
`default_nettype none

module pipe_tb
    import pipe_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DLY    = 1;
    localparam int N_TESTS      = 22;
    localparam int DRAIN_CYCLES = 20;

    logic                    clk;
    logic                    reset;
    logic                    in_valid;
    logic                    in_ready;
    pipe_op_t                in_op;
    logic [`PIPE_REG_AW-1:0] in_rd;
    logic [`PIPE_REG_AW-1:0] in_rs1;
    logic [`PIPE_REG_AW-1:0] in_rs2;
    logic [`PIPE_IMM_W-1:0]  in_imm;
    logic                    out_valid;
    logic                    out_ready;
    pipe_op_t                out_op;
    logic [`PIPE_REG_AW-1:0] out_rd;
    logic [`PIPE_XLEN-1:0]   out_value;

    // instruction table with the expected record value.
    pipe_op_t                t_op    [N_TESTS];
    logic [`PIPE_REG_AW-1:0] t_rd    [N_TESTS];
    logic [`PIPE_REG_AW-1:0] t_rs1   [N_TESTS];
    logic [`PIPE_REG_AW-1:0] t_rs2   [N_TESTS];
    logic [`PIPE_IMM_W-1:0]  t_imm   [N_TESTS];
    logic [`PIPE_XLEN-1:0]   t_value [N_TESTS];
    string                   t_name  [N_TESTS];

    int          n_entries = 0;
    int          errors    = 0;
    int          rx_count  = 0;
    logic [31:0] rng_state;

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

    pipe_top UUT (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
        .in_rd(in_rd), .in_rs1(in_rs1), .in_rs2(in_rs2), .in_imm(in_imm),
        .out_valid(out_valid), .out_ready(out_ready), .out_op(out_op),
        .out_rd(out_rd), .out_value(out_value)
    );

    bind pipe_top pipe_props u_props (
        .clk(clk), .reset(reset),
        .flush_exe(flush_exe), .in_ready(in_ready),
        .out_valid(out_valid), .out_ready(out_ready), .out_op(out_op),
        .out_rd(out_rd), .out_value(out_value)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_entry(input pipe_op_t op, input int rd, input int rs1, input int rs2,
                             input logic [15:0] imm, input logic [31:0] value,
                             input string name);
        t_op[n_entries]    = op;
        t_rd[n_entries]    = rd[`PIPE_REG_AW-1:0];
        t_rs1[n_entries]   = rs1[`PIPE_REG_AW-1:0];
        t_rs2[n_entries]   = rs2[`PIPE_REG_AW-1:0];
        t_imm[n_entries]   = imm;
        t_value[n_entries] = value;
        t_name[n_entries]  = name;
        n_entries++;
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED %s %s: expected %0h, actual %0h", name, field, expected, actual);
        end
    endtask

    // hand-worked values assume registers and memory start at zero.
    task automatic load_table();
        add_entry(OP_ADDI,  1,  0,  0, 16'd5,    32'd5,         "addi_x1");
        add_entry(OP_ADDI,  2,  0,  0, 16'd12,   32'd12,        "addi_x2");
        add_entry(OP_ADDI,  3,  0,  0, 16'hFFFD, 32'hFFFF_FFFD, "addi_neg");
        add_entry(OP_ADD,   4,  1,  2, 16'd0,    32'd17,        "add");
        add_entry(OP_SUB,   5,  2,  1, 16'd0,    32'd7,         "sub");
        add_entry(OP_AND,   6,  5,  2, 16'd0,    32'd4,         "and");
        add_entry(OP_OR,    7,  1,  2, 16'd0,    32'd13,        "or");
        add_entry(OP_ADD,   8,  7,  7, 16'd0,    32'd26,        "fwd_mem_both");
        add_entry(OP_SUB,   9,  8,  7, 16'd0,    32'd13,        "fwd_mem_wb");
        add_entry(OP_ADD,  10,  8,  9, 16'd0,    32'd39,        "fwd_wb_mem");
        add_entry(OP_ADDI, 11,  0,  0, 16'h40,   32'd64,        "addi_base");
        add_entry(OP_SW,    0, 11, 10, 16'd4,    32'd39,        "sw_fwd");
        add_entry(OP_LW,   12, 11,  0, 16'd4,    32'd39,        "lw_after_sw");
        add_entry(OP_ADD,  13, 12,  1, 16'd0,    32'd44,        "load_use");
        add_entry(OP_SW,    0,  0,  3, 16'h80,   32'hFFFF_FFFD, "sw_neg");
        add_entry(OP_LW,   14,  0,  0, 16'h80,   32'hFFFF_FFFD, "lw_neg");
        add_entry(OP_AND,  15, 14, 14, 16'd0,    32'hFFFF_FFFD, "load_use_both");
        add_entry(OP_LW,   16, 11,  0, 16'd0,    32'd0,         "lw_unwritten");
        add_entry(OP_ADDI,  0,  1,  0, 16'd100,  32'd105,       "addi_x0");
        add_entry(OP_ADD,  17,  0,  0, 16'd0,    32'd0,         "read_x0");
        add_entry(OP_ADD,  18,  0,  1, 16'd0,    32'd5,         "x0_plus_x1");
        add_entry(OP_OR,   19, 17, 18, 16'd0,    32'd5,         "or_fwd");
    endtask

    initial
    begin
        int i;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_op    = OP_ADD;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_imm   = '0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        for (i = 0; i < N_TESTS; i++)
        begin
            in_valid = 1'b1;
            in_op    = t_op[i];
            in_rd    = t_rd[i];
            in_rs1   = t_rs1[i];
            in_rs2   = t_rs2[i];
            in_imm   = t_imm[i];
            // in_ready is settled by the falling edge.
            @(negedge clk);
            while (!in_ready)
                @(negedge clk);
            @(posedge clk);
            #DRIVE_DLY;
        end
        in_valid = 1'b0;

        wait (rx_count == N_TESTS);
        // idle a while so that a stray extra record shows up.
        repeat (DRAIN_CYCLES) @(posedge clk);

        $display("errors: %0d, records: %0d of %0d", errors, rx_count, N_TESTS);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // random back-pressure with out_ready low about a quarter of the time.
    initial
    begin
        out_ready = 1'b0;
        rng_state = 32'd53;
        forever
        begin
            @(posedge clk);
            #DRIVE_DLY;
            rng_state = xorshift32(rng_state);
            out_ready = rng_state[1:0] != 2'b00;
        end
    end

    // records are checked at the falling edge ahead of their transfer.
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (!reset && out_valid && out_ready)
            begin
                if (rx_count < N_TESTS)
                begin
                    check_value(t_name[rx_count], "op", 32'(t_op[rx_count]), 32'(out_op));
                    check_value(t_name[rx_count], "rd", 32'(t_rd[rx_count]), 32'(out_rd));
                    check_value(t_name[rx_count], "value", t_value[rx_count], out_value);
                end
                else
                begin
                    errors++;
                    $display("error: result record arrived after the last table entry");
                end
                rx_count++;
            end
        end
    end

    initial
    begin
        #(CLK_PERIOD * (RESET_CYCLES + N_TESTS * 40));
        $display("timeout: only %0d of %0d result records arrived", rx_count, N_TESTS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : pipe_tb

`default_nettype wire

// File: pipe_props.sv
// concurrent checks on the hazard unit outputs and the result port.
// attached to pipe_top with bind from the testbench.
`timescale 1ns/1ps
`include "pipe_defs.svh"
`default_nettype none

module pipe_props
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush_exe,
    input  logic                    in_ready,
    input  logic                    out_valid,
    input  logic                    out_ready,
    input  pipe_op_t                out_op,
    input  logic [`PIPE_REG_AW-1:0] out_rd,
    input  logic [`PIPE_XLEN-1:0]   out_value
);

    // a flushed execute slot keeps the intake closed.
    flush_needs_stall: assert property (@(posedge clk) disable iff (reset)
        flush_exe |-> !in_ready)
        else $error("flush_exe high while the intake is open");

    // an offered record stays put until taken.
    out_record_held: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_op) && $stable(out_rd)
                                    && $stable(out_value))
        else $error("result record changed or dropped while out_ready was low");

    intake_closed_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !in_ready)
        else $error("in_ready high during reset");

endmodule : pipe_props

`default_nettype wire

// File: tb_clock.sv
// free-running testbench clock.
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
    parameter int PERIOD = 100
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2) clk = ~clk;
    end

endmodule : tb_clock

`default_nettype wire

// File: pipe_top.sv
// top level of the pipeline: intake, hazard unit, execute pipe, data
// memory and result port. the testbench drives in_ and out_ ports.
`timescale 1ns/1ps
`include "pipe_defs.svh"
`default_nettype none

module pipe_top
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  pipe_op_t                in_op,
    input  logic [`PIPE_REG_AW-1:0] in_rd,
    input  logic [`PIPE_REG_AW-1:0] in_rs1,
    input  logic [`PIPE_REG_AW-1:0] in_rs2,
    input  logic [`PIPE_IMM_W-1:0]  in_imm,
    output logic                    out_valid,
    input  logic                    out_ready,
    output pipe_op_t                out_op,
    output logic [`PIPE_REG_AW-1:0] out_rd,
    output logic [`PIPE_XLEN-1:0]   out_value
);

    logic                     id_valid;
    pipe_op_t                 id_op;
    logic [`PIPE_REG_AW-1:0]  id_rd;
    logic [`PIPE_REG_AW-1:0]  id_rs1;
    logic [`PIPE_REG_AW-1:0]  id_rs2;
    logic [`PIPE_IMM_W-1:0]   id_imm;
    logic [`PIPE_XLEN-1:0]    id_rd1;
    logic [`PIPE_XLEN-1:0]    id_rd2;
    bypass_sel_t              rd1_bypass;
    bypass_sel_t              rd2_bypass;
    logic                     stall_id;
    logic                     stall_exe;
    logic                     stall_mem;
    logic                     stall_wb;
    logic                     flush_exe;
    logic [`PIPE_REG_AW-1:0]  wa_exe;
    logic                     we_exe;
    logic                     load_exe;
    logic [`PIPE_REG_AW-1:0]  ra1_exe;
    logic [`PIPE_REG_AW-1:0]  ra2_exe;
    logic [`PIPE_REG_AW-1:0]  wa_mem;
    logic                     we_mem;
    logic                     mem_req;
    logic                     mem_we;
    logic [`PIPE_DMEM_AW-1:0] mem_addr;
    logic [`PIPE_XLEN-1:0]    mem_wdata;
    logic [`PIPE_XLEN-1:0]    mem_rdata;
    logic                     mem_ack;
    logic                     wb_valid;
    logic                     wb_we;
    pipe_op_t                 wb_op;
    logic [`PIPE_REG_AW-1:0]  wb_rd;
    logic [`PIPE_XLEN-1:0]    wb_value;
    logic                     full;
    logic                     req_ack;

    // result back-pressure joins the memory hold.
    assign req_ack = mem_ack && !full;

    instr_intake u_intake (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
        .in_rd(in_rd), .in_rs1(in_rs1), .in_rs2(in_rs2), .in_imm(in_imm),
        .stall_id(stall_id),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_value(wb_value),
        .id_valid(id_valid), .id_op(id_op), .id_rd(id_rd),
        .id_rs1(id_rs1), .id_rs2(id_rs2), .id_imm(id_imm),
        .id_rd1(id_rd1), .id_rd2(id_rd2)
    );

    hazard_unit u_hazard (
        .wa_mem(wa_mem), .we_mem(we_mem), .wa_wb(wb_rd), .we_wb(wb_we),
        .ra1_exe(ra1_exe), .ra2_exe(ra2_exe),
        .rd1_bypass(rd1_bypass), .rd2_bypass(rd2_bypass),
        .req_ack(req_ack),
        .wa_exe(wa_exe), .we_exe(we_exe), .load_exe(load_exe),
        .ra1_id(id_rs1), .ra2_id(id_rs2),
        .stall_id(stall_id), .stall_exe(stall_exe), .stall_mem(stall_mem),
        .stall_wb(stall_wb), .flush_exe(flush_exe)
    );

    exec_mem_pipe u_exec (
        .clk(clk), .reset(reset),
        .id_valid(id_valid), .id_op(id_op), .id_rd(id_rd),
        .id_rs1(id_rs1), .id_rs2(id_rs2), .id_imm(id_imm),
        .id_rd1(id_rd1), .id_rd2(id_rd2),
        .rd1_bypass(rd1_bypass), .rd2_bypass(rd2_bypass),
        .stall_exe(stall_exe), .stall_mem(stall_mem), .stall_wb(stall_wb),
        .flush_exe(flush_exe),
        .wa_exe(wa_exe), .we_exe(we_exe), .load_exe(load_exe),
        .ra1_exe(ra1_exe), .ra2_exe(ra2_exe), .wa_mem(wa_mem), .we_mem(we_mem),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack),
        .wb_valid(wb_valid), .wb_we(wb_we), .wb_op(wb_op),
        .wb_rd(wb_rd), .wb_value(wb_value)
    );

    data_mem u_dmem (
        .clk(clk), .reset(reset),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack)
    );

    result_port u_result (
        .clk(clk), .reset(reset),
        .wb_valid(wb_valid), .wb_op(wb_op), .wb_rd(wb_rd), .wb_value(wb_value),
        .full(full),
        .out_valid(out_valid), .out_ready(out_ready), .out_op(out_op),
        .out_rd(out_rd), .out_value(out_value)
    );

endmodule : pipe_top

`default_nettype wire

// File: result_port.sv
// output side: one-entry register for retired records, offered with
// valid/ready. full holds the pipeline while a record waits.
`timescale 1ns/1ps
`include "pipe_defs.svh"
`default_nettype none

module result_port
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wb_valid,
    input  pipe_op_t                wb_op,
    input  logic [`PIPE_REG_AW-1:0] wb_rd,
    input  logic [`PIPE_XLEN-1:0]   wb_value,
    output logic                    full,
    output logic                    out_valid,
    input  logic                    out_ready,
    output pipe_op_t                out_op,
    output logic [`PIPE_REG_AW-1:0] out_rd,
    output logic [`PIPE_XLEN-1:0]   out_value
);

    // a record leaving this cycle frees the slot for the next one.
    assign full = out_valid && !out_ready;

    // wb_valid only arrives while full is low.
    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else if (wb_valid)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (wb_valid)
        begin
            out_op    <= wb_op;
            out_rd    <= wb_rd;
            out_value <= wb_value;
        end
    end

endmodule : result_port

`default_nettype wire

// File: data_mem.sv
// data memory of 32-bit words with request/acknowledge handshake.
// an 8-bit LFSR picks the wait states of each request.
`timescale 1ns/1ps
`include "pipe_defs.svh"
`default_nettype none

module data_mem
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mem_req,
    input  logic                     mem_we,
    input  logic [`PIPE_DMEM_AW-1:0] mem_addr,
    input  logic [`PIPE_XLEN-1:0]    mem_wdata,
    output logic [`PIPE_XLEN-1:0]    mem_rdata,
    output logic                     mem_ack
);

    localparam int DEPTH  = 1 << `PIPE_DMEM_AW;
    localparam int WAIT_W = $clog2(`PIPE_DMEM_MAX_WAIT + 2);

    logic [`PIPE_XLEN-1:0] mem [DEPTH];
    logic [7:0]            lfsr;
    logic                  busy;
    logic [WAIT_W-1:0]     wait_cnt;
    logic [WAIT_W-1:0]     first_wait;
    logic [WAIT_W-1:0]     cur_wait;

    assign first_wait = WAIT_W'(lfsr % (`PIPE_DMEM_MAX_WAIT + 1));
    assign cur_wait   = busy ? wait_cnt : first_wait;

    // idle memory reports ack so non-memory stages never hold.
    assign mem_ack   = !mem_req || cur_wait == '0;
    assign mem_rdata = mem[mem_addr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lfsr     <= 8'hA5;
            busy     <= 1'b0;
            wait_cnt <= '0;
        end
        else
        begin
            // taps 8,6,5,4.
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            if (mem_req && !mem_ack)
            begin
                busy     <= 1'b1;
                wait_cnt <= cur_wait - 1'b1;
            end
            else
            begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= '0;
        end
        else if (mem_req && mem_we && mem_ack)
        begin
            mem[mem_addr] <= mem_wdata;
        end
    end

endmodule : data_mem

`default_nettype wire

// File: exec_mem_pipe.sv
// execute, memory and writeback stage registers with the ALU and the
// operand forwarding muxes. drives the data memory request in memory stage.
`timescale 1ns/1ps
`include "pipe_defs.svh"
`default_nettype none

module exec_mem_pipe
    import pipe_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     id_valid,
    input  pipe_op_t                 id_op,
    input  logic [`PIPE_REG_AW-1:0]  id_rd,
    input  logic [`PIPE_REG_AW-1:0]  id_rs1,
    input  logic [`PIPE_REG_AW-1:0]  id_rs2,
    input  logic [`PIPE_IMM_W-1:0]   id_imm,
    input  logic [`PIPE_XLEN-1:0]    id_rd1,
    input  logic [`PIPE_XLEN-1:0]    id_rd2,
    input  bypass_sel_t              rd1_bypass,
    input  bypass_sel_t              rd2_bypass,
    input  logic                     stall_exe,
    input  logic                     stall_mem,
    input  logic                     stall_wb,
    input  logic                     flush_exe,
    output logic [`PIPE_REG_AW-1:0]  wa_exe,
    output logic                     we_exe,
    output logic                     load_exe,
    output logic [`PIPE_REG_AW-1:0]  ra1_exe,
    output logic [`PIPE_REG_AW-1:0]  ra2_exe,
    output logic [`PIPE_REG_AW-1:0]  wa_mem,
    output logic                     we_mem,
    output logic                     mem_req,
    output logic                     mem_we,
    output logic [`PIPE_DMEM_AW-1:0] mem_addr,
    output logic [`PIPE_XLEN-1:0]    mem_wdata,
    input  logic [`PIPE_XLEN-1:0]    mem_rdata,
    input  logic                     mem_ack,
    output logic                     wb_valid,
    output logic                     wb_we,
    output pipe_op_t                 wb_op,
    output logic [`PIPE_REG_AW-1:0]  wb_rd,
    output logic [`PIPE_XLEN-1:0]    wb_value
);

    logic                  dec_we;
    logic                  exe_valid;
    pipe_op_t              exe_op;
    logic [`PIPE_IMM_W-1:0] exe_imm;
    logic [`PIPE_XLEN-1:0] exe_rd1;
    logic [`PIPE_XLEN-1:0] exe_rd2;
    logic [`PIPE_XLEN-1:0] src_a;
    logic [`PIPE_XLEN-1:0] src_b_reg;
    logic [`PIPE_XLEN-1:0] src_b;
    logic [`PIPE_XLEN-1:0] imm_ext;
    logic [`PIPE_XLEN-1:0] alu_out;
    logic                  mem_valid;
    pipe_op_t              mem_op;
    logic [`PIPE_XLEN-1:0] mem_alu;
    logic [`PIPE_XLEN-1:0] mem_sdata;
    logic [`PIPE_XLEN-1:0] mem_result;
    logic                  wb_valid_q;

    // stores and writes to x0 never update the register file.
    assign dec_we = id_valid && id_op != OP_SW && id_rd != '0;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            exe_valid <= 1'b0;
            we_exe    <= 1'b0;
        end
        else if (!stall_exe)
        begin
            // flush turns the slot into a bubble.
            exe_valid <= id_valid && !flush_exe;
            we_exe    <= dec_we && !flush_exe;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_exe)
        begin
            exe_op  <= id_op;
            wa_exe  <= id_rd;
            ra1_exe <= id_rs1;
            ra2_exe <= id_rs2;
            exe_imm <= id_imm;
            exe_rd1 <= id_rd1;
            exe_rd2 <= id_rd2;
        end
    end

    assign load_exe = exe_valid && exe_op == OP_LW;

    // loads never sit in memory with a dependent in execute, so mem_alu is safe.
    always_comb
    begin
        case (rd1_bypass)
            BP_MEM:  src_a = mem_alu;
            BP_WB:   src_a = wb_value;
            default: src_a = exe_rd1;
        endcase
        case (rd2_bypass)
            BP_MEM:  src_b_reg = mem_alu;
            BP_WB:   src_b_reg = wb_value;
            default: src_b_reg = exe_rd2;
        endcase
    end

    assign imm_ext = {{(`PIPE_XLEN - `PIPE_IMM_W){exe_imm[`PIPE_IMM_W-1]}}, exe_imm};
    assign src_b   = (exe_op == OP_ADDI || exe_op == OP_LW || exe_op == OP_SW) ?
                     imm_ext : src_b_reg;

    always_comb
    begin
        case (exe_op)
            OP_SUB:  alu_out = src_a - src_b;
            OP_AND:  alu_out = src_a & src_b;
            OP_OR:   alu_out = src_a | src_b;
            default: alu_out = src_a + src_b;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_valid <= 1'b0;
            we_mem    <= 1'b0;
        end
        else if (!stall_mem)
        begin
            mem_valid <= exe_valid;
            we_mem    <= we_exe;
        end
    end

    // store data is the forwarded rs2 value.
    always_ff @(posedge clk)
    begin
        if (!stall_mem)
        begin
            mem_op    <= exe_op;
            wa_mem    <= wa_exe;
            mem_alu   <= alu_out;
            mem_sdata <= src_b_reg;
        end
    end

    assign mem_req   = mem_valid && (mem_op == OP_LW || mem_op == OP_SW);
    assign mem_we    = mem_valid && mem_op == OP_SW;
    assign mem_addr  = mem_alu[`PIPE_DMEM_AW+1:2];
    assign mem_wdata = mem_sdata;

    assign mem_result = (mem_op == OP_LW) ? mem_rdata :
                        (mem_op == OP_SW) ? mem_sdata : mem_alu;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_valid_q <= 1'b0;
            wb_we      <= 1'b0;
        end
        else if (!stall_wb)
        begin
            wb_valid_q <= mem_valid;
            wb_we      <= we_mem;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_wb)
        begin
            wb_op    <= mem_op;
            wb_rd    <= wa_mem;
            wb_value <= mem_result;
        end
    end

    // retires only in the cycle the stage moves on, once per instruction.
    assign wb_valid = wb_valid_q && !stall_wb;

endmodule : exec_mem_pipe

`default_nettype wire

// File: hazard_unit.sv
// hazard unit: execute forwarding selects, load-use stall and the
// pipeline-wide hold from memory acknowledge and result back-pressure.
`timescale 1ns/1ps
`include "pipe_defs.svh"
`default_nettype none

module hazard_unit
    import pipe_pkg::*;
(
    input  logic                    [`PIPE_REG_AW-1:0] wa_mem,
    input  logic                                       we_mem,
    input  logic                    [`PIPE_REG_AW-1:0] wa_wb,
    input  logic                                       we_wb,
    input  logic                    [`PIPE_REG_AW-1:0] ra1_exe,
    input  logic                    [`PIPE_REG_AW-1:0] ra2_exe,
    output bypass_sel_t                                rd1_bypass,
    output bypass_sel_t                                rd2_bypass,
    input  logic                                       req_ack,
    input  logic                    [`PIPE_REG_AW-1:0] wa_exe,
    input  logic                                       we_exe,
    input  logic                                       load_exe,
    input  logic                    [`PIPE_REG_AW-1:0] ra1_id,
    input  logic                    [`PIPE_REG_AW-1:0] ra2_id,
    output logic                                       stall_id,
    output logic                                       stall_exe,
    output logic                                       stall_mem,
    output logic                                       stall_wb,
    output logic                                       flush_exe
);

    logic lw_stall;

    // younger producer in memory wins over writeback.
    always_comb
    begin
        rd1_bypass = BP_NONE;
        if (we_mem && wa_mem == ra1_exe)
            rd1_bypass = BP_MEM;
        else if (we_wb && wa_wb == ra1_exe)
            rd1_bypass = BP_WB;

        rd2_bypass = BP_NONE;
        if (we_mem && wa_mem == ra2_exe)
            rd2_bypass = BP_MEM;
        else if (we_wb && wa_wb == ra2_exe)
            rd2_bypass = BP_WB;
    end

    // load in execute feeding the instruction in decode.
    assign lw_stall = we_exe && load_exe && (wa_exe == ra1_id || wa_exe == ra2_id);

    assign stall_id  = lw_stall || !req_ack;
    assign stall_exe = !req_ack;
    assign stall_mem = !req_ack;
    assign stall_wb  = !req_ack;
    assign flush_exe = lw_stall;

endmodule : hazard_unit

`default_nettype wire

// File: instr_intake.sv
// intake and decode stage: valid/ready instruction input, the decode
// register and the register file, read write-first.
`timescale 1ns/1ps
`include "pipe_defs.svh"
`default_nettype none

module instr_intake
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  pipe_op_t                in_op,
    input  logic [`PIPE_REG_AW-1:0] in_rd,
    input  logic [`PIPE_REG_AW-1:0] in_rs1,
    input  logic [`PIPE_REG_AW-1:0] in_rs2,
    input  logic [`PIPE_IMM_W-1:0]  in_imm,
    input  logic                    stall_id,
    input  logic                    wb_we,
    input  logic [`PIPE_REG_AW-1:0] wb_rd,
    input  logic [`PIPE_XLEN-1:0]   wb_value,
    output logic                    id_valid,
    output pipe_op_t                id_op,
    output logic [`PIPE_REG_AW-1:0] id_rd,
    output logic [`PIPE_REG_AW-1:0] id_rs1,
    output logic [`PIPE_REG_AW-1:0] id_rs2,
    output logic [`PIPE_IMM_W-1:0]  id_imm,
    output logic [`PIPE_XLEN-1:0]   id_rd1,
    output logic [`PIPE_XLEN-1:0]   id_rd2
);

    localparam int NREGS = 1 << `PIPE_REG_AW;

    logic                  started;
    logic [`PIPE_XLEN-1:0] regs [NREGS];

    // keeps in_ready low for the first cycle out of reset.
    always_ff @(posedge clk)
    begin
        if (reset)
            started <= 1'b0;
        else
            started <= 1'b1;
    end

    assign in_ready = started && !stall_id;

    always_ff @(posedge clk)
    begin
        if (reset)
            id_valid <= 1'b0;
        else if (!stall_id)
            id_valid <= in_valid && in_ready;
    end

    // decode payload moves only when the stage is free.
    always_ff @(posedge clk)
    begin
        if (!stall_id)
        begin
            id_op  <= in_op;
            id_rd  <= in_rd;
            id_rs1 <= in_rs1;
            id_rs2 <= in_rs2;
            id_imm <= in_imm;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < NREGS; i++)
                regs[i] <= '0;
        end
        else if (wb_we && wb_rd != '0)
        begin
            regs[wb_rd] <= wb_value;
        end
    end

    // a result retiring this cycle is seen by decode directly.
    assign id_rd1 = (id_rs1 == '0)                  ? '0       :
                    (wb_we && wb_rd == id_rs1)      ? wb_value : regs[id_rs1];
    assign id_rd2 = (id_rs2 == '0)                  ? '0       :
                    (wb_we && wb_rd == id_rs2)      ? wb_value : regs[id_rs2];

endmodule : instr_intake

`default_nettype wire

// File: pipe_pkg.sv
// types shared by the pipeline blocks and the testbench.
// blocks pull them in with a wildcard import.
`default_nettype none

package pipe_pkg;

    // decoded operations accepted at intake.
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_ADDI = 3'd4,
        OP_LW   = 3'd5,
        OP_SW   = 3'd6
    } pipe_op_t;

    // where an execute operand comes from.
    typedef enum logic [1:0] {
        BP_NONE = 2'd0,
        BP_MEM  = 2'd1,
        BP_WB   = 2'd2
    } bypass_sel_t;

endpackage : pipe_pkg

`default_nettype wire

// File: pipe_defs.svh
// widths and sizing macros shared by the pipeline and its testbench.
// include ahead of the module header in any file that uses them.
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

`default_nettype none

// data path width.
`define PIPE_XLEN          32
// register index width, x0 always reads zero.
`define PIPE_REG_AW        5
// immediate field width, sign-extended in execute.
`define PIPE_IMM_W         16
// data memory word address width.
`define PIPE_DMEM_AW       8
// upper bound on wait states per memory request.
`define PIPE_DMEM_MAX_WAIT 3

`default_nettype wire

`endif
